// ==== source/tune_pkg.sv ====
// ------------------------------------------------
// tune description for the two-voice player
// note encoding, track timing and the fixed tune tables,
// shared by the sequencer, the pitch units and the testbench
// ------------------------------------------------
package tune_pkg;

	// upper nibble octave (bigger = lower pitch), lower nibble semitone
	typedef logic [7:0] note_t;

	localparam logic [3:0] OCT_SILENT = 4'hf;
	localparam note_t NOTE_SILENT = {OCT_SILENT, 4'h0};

	// track timing
	// ------------------------------------------------
	localparam int TRACK_LOG2_WAIT = 5; // 32 samples per chord
	localparam int TRACK_POS_BITS = 2; // four chords per loop
	localparam int BASS_POS_BITS = 4;
	localparam int BASS_LOG2_WAIT = TRACK_LOG2_WAIT - BASS_POS_BITS; // 16 bass steps per chord
	localparam int SAMPLE_COUNTER_BITS = TRACK_LOG2_WAIT + TRACK_POS_BITS + 1;

	typedef logic [SAMPLE_COUNTER_BITS-1:0] sample_count_t;

	// tune tables, indexed by track position
	// ------------------------------------------------
	localparam note_t CHORD_ROOTS [4] = '{8'h10, 8'h27, 8'h25, 8'h21}; // C1 G0 F0 Db0
	localparam note_t CHORD_ROOT_ALT = 8'h28; // Ab0, last chord with chords off

	localparam note_t BASS_NOTE1 [4] = '{8'h30, 8'h32, 8'h30, 8'h35};
	localparam note_t BASS_NOTE2 [4] = '{8'h37, 8'h37, 8'h35, 8'h38};

	// mantissa table
	// full values are 8 bits with the msb always set; the msb is dropped on lookup
	localparam int MANTISSA_BITS = 7;
	localparam logic [7:0] MANTISSA_TABLE [16] = '{
		8'd246, 8'd232, 8'd219, 8'd207,
		8'd195, 8'd184, 8'd174, 8'd164,
		8'd155, 8'd146, 8'd138, 8'd130,
		8'd0, 8'd0, 8'd0, 8'd0 // unused semitones
	};

endpackage

// ==== source/synth_pkg.sv ====
// ------------------------------------------------
// microcoded ALU definitions
// word width, operand and destination encodings, the
// instruction format and the program length per sample
// ------------------------------------------------
package synth_pkg;

	localparam int A_BITS = 12;
	typedef logic [A_BITS-1:0] word_t;

	localparam int PROG_LEN = 8; // instructions per sample
	typedef logic [$clog2(PROG_LEN)-1:0] step_idx_t;

	// operand sources
	// ------------------------------------------------
	typedef enum logic {
		A_ZERO,
		A_ACC
	} a_src_t;

	typedef enum logic [2:0] {
		S_ZERO,
		S_PHASE_CHORD,
		S_PHASE_BASS,
		S_STEP_CHORD,
		S_STEP_BASS
	} s_src_t;

	// register file
	// ------------------------------------------------
	localparam int REG_PHASE_CHORD = 0;
	localparam int REG_PHASE_BASS = 1;
	localparam int REG_OUTPUT = 2;
	localparam int NUM_REGS = 3;

	typedef logic [NUM_REGS-1:0] dest_mask_t;

	localparam dest_mask_t DEST_NONE = '0;
	localparam dest_mask_t DEST_PHASE_CHORD = dest_mask_t'(1 << REG_PHASE_CHORD);
	localparam dest_mask_t DEST_PHASE_BASS = dest_mask_t'(1 << REG_PHASE_BASS);
	localparam dest_mask_t DEST_OUTPUT = dest_mask_t'(1 << REG_OUTPUT);

	// one microinstruction
	typedef struct packed {
		a_src_t a_src;
		s_src_t s_src;
		logic update_acc; // acc <= a + s
		dest_mask_t dest_mask; // regs <= acc (old value)
	} instr_t;

	localparam instr_t INSTR_NOP = '{
		a_src: A_ZERO,
		s_src: S_ZERO,
		update_acc: 1'b0,
		dest_mask: DEST_NONE
	};

endpackage

// ==== source/tune_sequencer.sv ====
// ------------------------------------------------
// tune sequencer
// counts samples and picks the chord and bass notes
// for the current track and bass position
// ------------------------------------------------
module tune_sequencer import tune_pkg::*; (
	input logic clk,
	input logic reset,
	input logic sample_done, // last step of a sample
	input logic chords_on,
	input logic simple_bass,
	input logic silence,
	output note_t chord_note,
	output note_t bass_note
);

	sample_count_t sample_count;
	logic [TRACK_POS_BITS-1:0] track_pos;
	logic [BASS_POS_BITS-1:0] bass_pos;
	logic chord_gap;
	note_t root;
	note_t note1;
	note_t note2;

	// sample counter, advances once per finished sample
	always_ff @(posedge clk) begin
		if (reset) begin
			sample_count <= '0;
		end else if (sample_done) begin
			sample_count <= sample_count + 1'b1; // wraps after two loops
		end
	end

	assign track_pos = sample_count[TRACK_LOG2_WAIT +: TRACK_POS_BITS];
	assign bass_pos = sample_count[BASS_LOG2_WAIT +: BASS_POS_BITS];
	assign chord_gap = (bass_pos < 2); // short rest at each chord start

	// chord voice
	// ------------------------------------------------
	always_comb begin
		root = CHORD_ROOTS[track_pos];
		if (track_pos == 2'd3 && !chords_on) root = CHORD_ROOT_ALT;
		chord_note = (silence || chord_gap) ? NOTE_SILENT : root;
	end

	// bass voice
	// ------------------------------------------------
	assign note1 = BASS_NOTE1[track_pos];
	assign note2 = BASS_NOTE2[track_pos];

	always_comb begin
		bass_note = NOTE_SILENT; // rest unless a pattern hits
		if (simple_bass) begin
			case (bass_pos)
				0, 2, 4, 8, 12, 14: bass_note = note1;
				1, 6, 10, 13: bass_note = note2;
				default: bass_note = NOTE_SILENT;
			endcase
		end else if (track_pos != 2'd3) begin
			case (bass_pos)
				0, 2, 4, 5, 8, 12, 13: bass_note = note1;
				1, 6, 10, 14: bass_note = note2;
				default: bass_note = NOTE_SILENT;
			endcase
		end else begin
			// last chord gets its own groove
			case (bass_pos)
				0, 4, 8, 9, 12: bass_note = note1;
				2, 6, 10, 14: bass_note = note2;
				default: bass_note = NOTE_SILENT;
			endcase
		end
		if (silence) bass_note = NOTE_SILENT;
	end

endmodule

// ==== source/note_to_step.sv ====
// ------------------------------------------------
// note to phase increment
// mantissa lookup plus octave shift, combinational;
// a silent octave yields a zero step
// ------------------------------------------------
module note_to_step import tune_pkg::*, synth_pkg::*; (
	input note_t note,
	output word_t step
);

	localparam int PAD_BITS = A_BITS - 1 - MANTISSA_BITS; // low zeros below mantissa

	logic [3:0] octave;
	logic [3:0] semitone;
	logic [MANTISSA_BITS-1:0] mantissa;
	word_t unshifted;

	assign octave = note[7:4];
	assign semitone = note[3:0];

	// rom read, keep the low bits only
	assign mantissa = MANTISSA_TABLE[semitone][MANTISSA_BITS-1:0];

	// mantissa in the upper bits of an 11-bit field, msb of word stays clear
	assign unshifted = {1'b0, mantissa, {PAD_BITS{1'b0}}};

	// one octave down per shift
	assign step = (octave == OCT_SILENT) ? '0 : (unshifted >> octave);

endmodule

// ==== source/alu_program.sv ====
// ------------------------------------------------
// microprogram sequencer
// steps through the eight-instruction program once per
// sample and flags the last step
// ------------------------------------------------
module alu_program import synth_pkg::*; (
	input logic clk,
	input logic reset,
	output instr_t instr,
	output logic sample_done
);

	step_idx_t step;
	instr_t rom_instr;

	always_ff @(posedge clk) begin
		if (reset) begin
			step <= '0;
		end else if (step == step_idx_t'(PROG_LEN - 1)) begin
			step <= '0;
		end else begin
			step <= step + 1'b1;
		end
	end

	// microcode rom
	// ------------------------------------------------
	always_comb begin
		rom_instr = INSTR_NOP;
		case (step)
			// chord phase += chord step
			3'd0: rom_instr = '{A_ZERO, S_PHASE_CHORD, 1'b1, DEST_NONE};
			3'd1: rom_instr = '{A_ACC, S_STEP_CHORD, 1'b1, DEST_NONE};
			// store chord, then bass phase += bass step
			3'd2: rom_instr = '{A_ZERO, S_PHASE_BASS, 1'b1, DEST_PHASE_CHORD};
			3'd3: rom_instr = '{A_ACC, S_STEP_BASS, 1'b1, DEST_NONE};
			// store bass, then mix both phases
			3'd4: rom_instr = '{A_ZERO, S_PHASE_CHORD, 1'b1, DEST_PHASE_BASS};
			3'd5: rom_instr = '{A_ACC, S_PHASE_BASS, 1'b1, DEST_NONE};
			3'd6: rom_instr = '{A_ZERO, S_ZERO, 1'b0, DEST_OUTPUT}; // publish the mix
			default: rom_instr = INSTR_NOP; // idle slot
		endcase
	end

	assign instr = reset ? INSTR_NOP : rom_instr;
	assign sample_done = (step == step_idx_t'(PROG_LEN - 1));

endmodule

// ==== source/synth_alu.sv ====
// ------------------------------------------------
// 12-bit ALU with accumulator and register file
// executes one microinstruction per clock; the output
// register holds the latest mixed sample
// ------------------------------------------------
module synth_alu import synth_pkg::*; (
	input logic clk,
	input logic reset,
	input instr_t instr,
	input word_t chord_step,
	input word_t bass_step,
	output word_t sample
);

	word_t acc; // accumulator
	word_t regs [NUM_REGS]; // chord phase, bass phase, output
	word_t a_val;
	word_t s_val;
	word_t sum;

	// operand selection
	// ------------------------------------------------
	always_comb begin
		case (instr.a_src)
			A_ACC: a_val = acc;
			default: a_val = '0;
		endcase
	end

	always_comb begin
		case (instr.s_src)
			S_PHASE_CHORD: s_val = regs[REG_PHASE_CHORD];
			S_PHASE_BASS: s_val = regs[REG_PHASE_BASS];
			S_STEP_CHORD: s_val = chord_step;
			S_STEP_BASS: s_val = bass_step;
			default: s_val = '0;
		endcase
	end

	assign sum = a_val + s_val; // wraps mod 4096

	// state update
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (instr.update_acc) begin
			acc <= sum;
		end
	end

	// register writes take acc before this clock's update
	genvar i;
	generate
		for (i = 0; i < NUM_REGS; i++) begin : g_regs
			always_ff @(posedge clk) begin
				if (reset) begin
					regs[i] <= '0;
				end else if (instr.dest_mask[i]) begin
					regs[i] <= acc;
				end
			end
		end
	endgenerate

	assign sample = regs[REG_OUTPUT];

endmodule

// ==== source/chiptune_player.sv ====
// ------------------------------------------------
// two-voice chiptune player, top level
// static controls in, one 12-bit sample every eight
// clocks out, flagged by sample_valid
// ------------------------------------------------
module chiptune_player import tune_pkg::*, synth_pkg::*; (
	input logic clk,
	input logic reset,
	input logic chords_on,
	input logic simple_bass,
	input logic silence,
	output word_t sample,
	output logic sample_valid
);

	note_t chord_note;
	note_t bass_note;
	word_t chord_step;
	word_t bass_step;
	instr_t instr;
	logic sample_done;

	tune_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.sample_done(sample_done),
		.chords_on(chords_on),
		.simple_bass(simple_bass),
		.silence(silence),
		.chord_note(chord_note),
		.bass_note(bass_note)
	);

	note_to_step u_chord_step (.note(chord_note), .step(chord_step));
	note_to_step u_bass_step (.note(bass_note), .step(bass_step));

	alu_program u_program (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.sample_done(sample_done)
	);

	synth_alu u_alu (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.chord_step(chord_step),
		.bass_step(bass_step),
		.sample(sample)
	);

	// valid during step 0, output written at end of step 6
	always_ff @(posedge clk) begin
		if (reset) begin
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= sample_done;
		end
	end

endmodule

// ==== test/chiptune_player_props.sv ====
// ------------------------------------------------
// sample_valid timing checks, bound into the top level
// ------------------------------------------------
module chiptune_player_props import synth_pkg::*; (
	input logic clk,
	input logic reset,
	input logic sample_valid
);

	logic [3:0] gap; // clocks since reset release or last pulse

	always_ff @(posedge clk) begin
		if (reset) begin
			gap <= '0;
		end else if (sample_valid) begin
			gap <= 4'd1;
		end else if (gap != 4'hf) begin
			gap <= gap + 1'b1; // saturates
		end
	end

	a_quiet_in_reset: assert property (@(posedge clk) reset |=> !sample_valid)
		else $error("sample_valid high right after a reset clock");

	a_one_clock: assert property (@(posedge clk) disable iff (reset)
		sample_valid |=> !sample_valid)
		else $error("sample_valid held longer than one clock");

	// first pulse and every later one exactly one program apart
	a_spacing: assert property (@(posedge clk) disable iff (reset)
		sample_valid |-> gap == 4'(PROG_LEN))
		else $error("sample_valid pulse not one program length after the last");

endmodule

bind chiptune_player chiptune_player_props u_props (
	.clk(clk),
	.reset(reset),
	.sample_valid(sample_valid)
);

// ==== test/chiptune_player_tb.sv ====
// ------------------------------------------------
// testbench for the two-voice chiptune player
// directed tests against a per-sample model of the tune
// notes, the mantissa steps and the phase sums
// ------------------------------------------------
module chiptune_player_tb import tune_pkg::*, synth_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int unsigned SEED = 32'hdc8e;
	localparam int LOOP_LEN = 1 << (TRACK_LOG2_WAIT + TRACK_POS_BITS); // samples per loop
	localparam int TOTAL_SAMPLES = 24 + 64 + 2 * LOOP_LEN + LOOP_LEN + 48;
	localparam int TIMEOUT_CYCLES = TOTAL_SAMPLES * PROG_LEN + 200; // margin for resets

	// bass hit masks with one bit per bass position
	localparam logic [15:0] SIMPLE_N1 = 16'h5115; // 0 2 4 8 12 14
	localparam logic [15:0] SIMPLE_N2 = 16'h2442; // 1 6 10 13
	localparam logic [15:0] NORMAL_N1 = 16'h3135; // 0 2 4 5 8 12 13
	localparam logic [15:0] NORMAL_N2 = 16'h4442; // 1 6 10 14
	localparam logic [15:0] LAST_N1 = 16'h1311; // 0 4 8 9 12
	localparam logic [15:0] LAST_N2 = 16'h4444; // 2 6 10 14

	logic clk;
	logic reset;
	logic chords_on;
	logic simple_bass;
	logic silence;
	word_t sample;
	logic sample_valid;

	word_t model_chord_phase;
	word_t model_bass_phase;
	sample_count_t model_count;
	int error_count;
	int cycle_count = 0;

	chiptune_player u_dut (
		.clk(clk),
		.reset(reset),
		.chords_on(chords_on),
		.simple_bass(simple_bass),
		.silence(silence),
		.sample(sample),
		.sample_valid(sample_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// reporting and compare tasks
	// ------------------------------------------------
	task automatic report_failure(input string reason);
		error_count = error_count + 1;
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_sample(input word_t got, input word_t expected, input string what);
		if (got !== expected)
			report_failure($sformatf("Mismatch at time %0t: %s, got 0x%03h expected 0x%03h",
				$time, what, got, expected));
	endtask

	task automatic check_count(input int got, input int expected, input string what);
		if (got != expected)
			report_failure($sformatf("Mismatch at time %0t: %s, got %0d expected %0d",
				$time, what, got, expected));
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_failure("timeout: the tests ran past their cycle limit");
	end

	// reference model
	// ------------------------------------------------
	function automatic word_t note_step(input note_t note);
		logic [10:0] field; // mantissa in the top seven bits
		if (note[7:4] == 4'hf) return '0; // silent octave
		field = {MANTISSA_TABLE[note[3:0]][MANTISSA_BITS-1:0], 4'b0000};
		return {1'b0, field >> note[7:4]}; // one octave down per shift
	endfunction

	function automatic note_t model_chord(input sample_count_t count);
		logic [1:0] track;
		logic [3:0] pos;
		track = 2'(count >> TRACK_LOG2_WAIT);
		pos = 4'(count >> BASS_LOG2_WAIT);
		if (silence || pos < 4'd2) return NOTE_SILENT; // gap at chord start
		if (track == 2'd3 && !chords_on) return CHORD_ROOT_ALT;
		return CHORD_ROOTS[track];
	endfunction

	function automatic note_t model_bass(input sample_count_t count);
		logic [1:0] track;
		logic [3:0] pos;
		logic [15:0] mask1;
		logic [15:0] mask2;
		track = 2'(count >> TRACK_LOG2_WAIT);
		pos = 4'(count >> BASS_LOG2_WAIT);
		mask1 = simple_bass ? SIMPLE_N1 : (track == 2'd3) ? LAST_N1 : NORMAL_N1;
		mask2 = simple_bass ? SIMPLE_N2 : (track == 2'd3) ? LAST_N2 : NORMAL_N2;
		if (silence) return NOTE_SILENT;
		if (mask1[pos]) return BASS_NOTE1[track];
		if (mask2[pos]) return BASS_NOTE2[track];
		return NOTE_SILENT;
	endfunction

	// one model sample with the controls as currently driven
	task automatic model_advance(output word_t expected);
		model_chord_phase = model_chord_phase + note_step(model_chord(model_count));
		model_bass_phase = model_bass_phase + note_step(model_bass(model_count));
		model_count = model_count + 1'b1;
		expected = model_chord_phase + model_bass_phase; // wraps mod 4096
	endtask

	// drive and wait
	// ------------------------------------------------
	task automatic apply_reset(input logic chords, input logic simple, input logic quiet);
		reset = 1'b1;
		chords_on = chords;
		simple_bass = simple;
		silence = quiet;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		model_chord_phase = '0;
		model_bass_phase = '0;
		model_count = '0;
	endtask

	// returns one tick after the edge that raised sample_valid
	task automatic wait_valid(output int clocks);
		clocks = 0;
		do begin
			@(posedge clk);
			#1 clocks = clocks + 1;
		end while (!sample_valid && clocks < 2 * PROG_LEN);
		if (!sample_valid)
			report_failure("sample_valid did not arrive within two sample periods");
	endtask

	task automatic run_samples(input int count, input string what);
		word_t expected;
		int clocks;
		for (int i = 0; i < count; i++) begin
			wait_valid(clocks);
			model_advance(expected);
			check_sample(sample, expected, what);
		end
	endtask

	// directed tests
	// ------------------------------------------------
	task automatic test_reset_and_timing();
		int clocks;
		int pulses;
		apply_reset(1'b1, 1'b0, 1'b0);
		check_sample(sample, '0, "sample right after reset");
		wait_valid(clocks);
		check_count(clocks, PROG_LEN, "clocks from reset release to first pulse");
		for (int i = 0; i < 15; i++) begin
			wait_valid(clocks);
			check_count(clocks, PROG_LEN, "clocks between sample_valid pulses");
		end
		pulses = 0;
		repeat (8 * PROG_LEN) begin
			@(posedge clk);
			#1 if (sample_valid) pulses = pulses + 1;
		end
		check_count(pulses, 8, "pulses in 64 clocks");
	endtask

	task automatic test_silence();
		int clocks;
		apply_reset(1'b1, 1'b0, 1'b1);
		for (int i = 0; i < 64; i++) begin
			wait_valid(clocks);
			check_sample(sample, '0, "sample with silence high");
		end
	endtask

	task automatic test_full_loop(input logic simple, input string what);
		apply_reset(1'b1, simple, 1'b0);
		run_samples(LOOP_LEN, what);
	endtask

	// chord 3 takes the alternate root, then silence freezes the phases
	task automatic test_alt_root_and_hold();
		int toggle_at;
		int clocks;
		word_t held;
		apply_reset(1'b0, 1'b0, 1'b0);
		run_samples(LOOP_LEN, "loop with chords off");
		toggle_at = $urandom_range(31, 1);
		run_samples(toggle_at, "samples before silence toggle");
		silence = 1'b1; // takes effect from the next sample
		held = model_chord_phase + model_bass_phase;
		for (int i = 0; i < 16; i++) begin
			wait_valid(clocks);
			check_sample(sample, held, "held sample after silence");
		end
		silence = 1'b0;
	endtask

	initial begin
		error_count = 0;
		reset = 1'b1;
		chords_on = 1'b0;
		simple_bass = 1'b0;
		silence = 1'b0;
		void'($urandom(SEED));
		test_reset_and_timing();
		test_silence();
		test_full_loop(1'b0, "normal bass loop");
		test_full_loop(1'b1, "simple bass loop");
		test_alt_root_and_hold();
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
source/tune_pkg.sv
source/synth_pkg.sv
source/tune_sequencer.sv
source/note_to_step.sv
source/alu_program.sv
source/synth_alu.sv
source/chiptune_player.sv
test/chiptune_player_props.sv
test/chiptune_player_tb.sv

// ==== Makefile ====
# Verilator build and run of the chiptune player testbench

VERILATOR ?= verilator
TOP ?= chiptune_player_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
